// ==== run.sh ====
#!/bin/sh
# build the FME testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary -f src.f --top-module fme_tb -o sim_fme

out=$(./obj_dir/sim_fme)
echo "$out"

# pass only when the testbench reports it
echo "$out" | grep -qF '*** PASSED ***'

// ==== src.f ====
+incdir+verilog
verilog/fme_pkg.sv
verilog/fme_mb_info.sv
verilog/fme_part_ctrl.sv
verilog/fme_result.sv
verilog/fme_top.sv
testbench/fme_tb.sv

// ==== testbench/fme_input.txt ====
// one macroblock per line: info[31:16] = {sub3, sub2, sub1, sub0, mb_type}
// qp[15:8], expected srch_start_o count[7:0]
0000_14_02
0001_1c_04
0002_22_04
0003_1a_08
3443_28_0c
029b_10_0c
124b_1e_10
2493_2a_08
36db_33_10
36dd_0f_02
0183_24_08

// ==== testbench/fme_tb.sv ====
// FME testbench
// reads macroblock type info from a data file, models the sub-pel search
// engine, and checks requests, fmv writeback, inter cost and timing
`timescale 1ns/100ps
`include "fme_params.svh"

module fme_tb import fme_pkg::*; ();

  localparam int MB_NUM = 11;

  logic          clk_i;
  logic          rst_n_i;
  logic          start_fme_i;
  qp_t           qp_i;
  imv_vec_t      imv_i;
  mb_type_info_t mb_type_info_i;
  logic          srch_start_o;
  srch_req_t     srch_req_o;
  logic          srch_done_i;
  srch_rsp_t     srch_rsp_i;
  logic          done_fme_o;
  fmv_vec_t      fmv_o;
  imv_vec_t      imv_o;
  mb_type_info_t mb_type_info_o;
  intercost_t    intercost_o;

  logic [31:0]   mb_mem [MB_NUM];   // {info, qp, search count}
  logic [31:0]   lfsr;
  int            errors = 0;
  int            checks = 0;
  int            start_cnt = 0;
  int            done_cnt = 0;
  int            total_srch = 0;
  logic          limit_ready = 1'b0;

  part_shape_e   step_shape[$];
  blk_addr_t     step_base[$];
  fmv_t          exp_fmv [`BLK4X4_NUM];
  intercost_t    exp_cost;

  fme_top DUT (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .start_fme_i    (start_fme_i),
    .qp_i           (qp_i),
    .imv_i          (imv_i),
    .mb_type_info_i (mb_type_info_i),
    .srch_start_o   (srch_start_o),
    .srch_req_o     (srch_req_o),
    .srch_done_i    (srch_done_i),
    .srch_rsp_i     (srch_rsp_i),
    .done_fme_o     (done_fme_o),
    .fmv_o          (fmv_o),
    .imv_o          (imv_o),
    .mb_type_info_o (mb_type_info_o),
    .intercost_o    (intercost_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // pulse counters sampled mid cycle
  always @(negedge clk_i) begin
    if (srch_start_o) start_cnt++;
    if (done_fme_o) done_cnt++;
  end

  // --------------------
  // helpers
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check(input logic [383:0] got, input logic [383:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  function automatic void add_step(input part_shape_e sh, input blk_addr_t b);
    step_shape.push_back(sh);
    step_base.push_back(b);
  endfunction

  // step list by macroblock and sub types
  function automatic void build_steps(input mb_type_info_t info);
    step_shape.delete();
    step_base.delete();
    case (info.mb_type)
      P_L0_L0_16X8: begin
        add_step(SHAPE_16X8, 4'd0);
        add_step(SHAPE_16X8, 4'd8);
      end
      P_L0_L0_8X16: begin
        add_step(SHAPE_8X16, 4'd0);
        add_step(SHAPE_8X16, 4'd4);
      end
      P_8X8: begin
        for (int p = 0; p < 4; p++) begin
          case (info.sub_type[p])
            P_L0_8X4: begin
              add_step(SHAPE_8X4, 4'(4*p));
              add_step(SHAPE_8X4, 4'(4*p+2));
            end
            P_L0_4X8: add_step(SHAPE_4X8, 4'(4*p));
            P_L0_4X4: begin
              add_step(SHAPE_4X4, 4'(4*p));
              add_step(SHAPE_4X4, 4'(4*p+2));
            end
            default:  add_step(SHAPE_8X8, 4'(4*p));
          endcase
        end
      end
      default: add_step(SHAPE_16X16, 4'd0);
    endcase
  endfunction

  // expected slots after a quarter pel response
  function automatic void apply_quarter(input part_shape_e sh, input int b, input srch_rsp_t rsp);
    case (sh)
      SHAPE_16X16: for (int k = 0; k < 16; k++) exp_fmv[k] = rsp.fmv0;
      SHAPE_16X8:  for (int k = 0; k < 8; k++) exp_fmv[b+k] = rsp.fmv0;
      SHAPE_8X16: begin
        for (int k = 0; k < 4; k++) begin
          exp_fmv[b+k]   = rsp.fmv0;
          exp_fmv[b+8+k] = rsp.fmv0;
        end
      end
      SHAPE_8X8:   for (int k = 0; k < 4; k++) exp_fmv[b+k] = rsp.fmv0;
      SHAPE_8X4: begin
        exp_fmv[b]   = rsp.fmv0;
        exp_fmv[b+1] = rsp.fmv0;
      end
      SHAPE_4X8: begin
        exp_fmv[b]   = rsp.fmv0;
        exp_fmv[b+2] = rsp.fmv0;
        exp_fmv[b+1] = rsp.fmv1;
        exp_fmv[b+3] = rsp.fmv1;
      end
      default: begin                          // 4x4
        exp_fmv[b]   = rsp.fmv0;
        exp_fmv[b+1] = rsp.fmv1;
      end
    endcase
    exp_cost = exp_cost + intercost_t'(rsp.cost);
  endfunction

  // --------------------
  // one macroblock with the engine model
  task automatic run_mb(input logic [31:0] word);
    mb_type_info_t info;
    qp_t           qp;
    int            exp_cnt;
    int            start_base;
    int            dly;
    imv_vec_t      imv_lat;
    imv_vec_t      imv_junk;
    srch_rsp_t     rsp;
    srch_req_t     exp_req;
    info    = mb_type_info_t'(word[30:16]);
    qp      = qp_t'(word[13:8]);
    exp_cnt = int'(word[7:0]);
    for (int k = 0; k < 16; k++) begin
      imv_lat[k]  = mv_t'(rand_bits(20));
      imv_junk[k] = mv_t'(rand_bits(20));
    end
    build_steps(info);
    for (int k = 0; k < 16; k++) exp_fmv[k] = '0;
    exp_cost   = '0;
    start_base = start_cnt;
    @(posedge clk_i);
    start_fme_i    <= 1'b1;
    imv_i          <= imv_lat;
    mb_type_info_i <= info;
    qp_i           <= qp;
    @(posedge clk_i);
    start_fme_i <= 1'b0;
    imv_i       <= imv_junk;                   // must not leak into the run
    @(negedge clk_i);
    for (int s = 0; s < step_shape.size(); s++) begin
      for (int pass = 0; pass < 2; pass++) begin
        // cleared at start, half pel results never land
        for (int k = 0; k < 16; k++) begin
          check(384'(fmv_o[k]), 384'(exp_fmv[k]),
                $sformatf("fmv block %0d before step %0d pass %0d", k, s, pass));
        end
        check(384'(intercost_o), 384'(exp_cost),
              $sformatf("intercost before step %0d pass %0d", s, pass));
        check(384'(srch_start_o), 384'(1'b1), "srch_start_o one cycle after start or done");
        exp_req.half  = (pass == 0);
        exp_req.shape = step_shape[s];
        exp_req.imv0  = imv_lat[step_base[s]];
        exp_req.imv1  = imv_lat[step_base[s] + 4'd1];
        exp_req.qp    = qp;
        check(384'(srch_req_o), 384'(exp_req), $sformatf("request step %0d pass %0d", s, pass));
        dly       = int'(rand_bits(3) % 6);
        rsp.fmv0  = fmv_t'(rand_bits(24));
        rsp.fmv1  = fmv_t'(rand_bits(24));
        rsp.cost  = cost_t'(rand_bits(16));
        @(posedge clk_i);
        if (s == 0 && pass == 0) begin
          start_fme_i    <= 1'b1;              // stray start while busy
          mb_type_info_i <= ~info;
          qp_i           <= ~qp;
        end
        repeat (dly) begin
          @(posedge clk_i);
          start_fme_i <= 1'b0;
        end
        srch_done_i <= 1'b1;
        srch_rsp_i  <= rsp;
        if (pass == 1) apply_quarter(step_shape[s], int'(step_base[s]), rsp);
        @(posedge clk_i);
        srch_done_i <= 1'b0;
        start_fme_i <= 1'b0;
        @(negedge clk_i);
      end
    end
    check(384'(done_fme_o), 384'(1'b1), "done_fme_o one cycle after last srch_done_i");
    check(384'(srch_start_o), 384'(1'b0), "no request after last step");
    for (int k = 0; k < 16; k++) begin
      check(384'(fmv_o[k]), 384'(exp_fmv[k]), $sformatf("fmv block %0d", k));
    end
    check(384'(intercost_o), 384'(exp_cost), "intercost");
    check(384'(imv_o), 384'(imv_lat), "imv echo");
    check(384'(mb_type_info_o), 384'(info), "mb_type_info echo");
    check(384'(2*step_shape.size()), 384'(exp_cnt), "step list against file count");
    check(384'(start_cnt - start_base), 384'(exp_cnt), "srch_start_o pulse count");
    @(negedge clk_i);
    check(384'(done_fme_o), 384'(1'b0), "done_fme_o one cycle wide");
  endtask

  // --------------------
  // main sequence
  initial begin
    lfsr           = 32'h9526d016;
    rst_n_i        = 1'b0;
    start_fme_i    = 1'b0;
    qp_i           = '0;
    imv_i          = '0;
    mb_type_info_i = '0;
    srch_done_i    = 1'b0;
    srch_rsp_i     = '0;
    $readmemh("testbench/fme_input.txt", mb_mem);
    if ($isunknown(mb_mem[MB_NUM-1])) begin
      errors++;
      $display("input file testbench/fme_input.txt could not be read in full");
    end
    for (int i = 0; i < MB_NUM; i++) total_srch += int'(mb_mem[i][7:0]);
    limit_ready = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check(384'(srch_start_o), 384'(1'b0), "srch_start_o after reset");
      check(384'(done_fme_o), 384'(1'b0), "done_fme_o after reset");
      check(384'(srch_req_o), 384'(0), "srch_req_o after reset");
      check(384'(fmv_o), 384'(0), "fmv_o after reset");
      check(384'(intercost_o), 384'(0), "intercost_o after reset");
      check(384'(imv_o), 384'(0), "imv_o after reset");
      check(384'(mb_type_info_o), 384'(0), "mb_type_info_o after reset");
    end
    for (int m = 0; m < MB_NUM; m++) run_mb(mb_mem[m]);
    check(384'(done_cnt), 384'(MB_NUM), "done_fme_o pulse count");
    $display("%0d macroblocks, %0d checks, %0d errors", MB_NUM, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog scaled by the number of searches in the file
  initial begin
    int limit;
    wait (limit_ready);
    limit = total_srch * 10 + 100;
    repeat (limit) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== verilog/fme_mb_info.sv ====
// FME macroblock info
// holds the IME motion vectors, type info and QP of the current macroblock
// and selects the sub type and motion vector pair for the running step
`timescale 1ns/100ps

module fme_mb_info import fme_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          load_i,
  input  imv_vec_t      imv_i,
  input  mb_type_info_t mb_type_info_i,
  input  qp_t           qp_i,
  input  logic [1:0]    part_i,
  input  blk_addr_t     base_i,
  output mb_type_e      mb_type_o,
  output sub_mb_type_e  sub_mb_type_o,
  output mv_t           imv0_o,
  output mv_t           imv1_o,
  output qp_t           qp_o,
  output imv_vec_t      imv_o,
  output mb_type_info_t mb_type_info_o
);

  imv_vec_t      imv_r;
  mb_type_info_t info_r;
  qp_t           qp_r;
  blk_addr_t     base_nxt;

  // --------------------
  // latch on start
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      imv_r  <= '0;
      info_r <= '0;
      qp_r   <= '0;
    end else if (load_i) begin
      imv_r  <= imv_i;
      info_r <= mb_type_info_i;
      qp_r   <= qp_i;
    end
  end

  // --------------------
  // selects
  assign mb_type_o     = mb_type_e'(info_r.mb_type);
  assign sub_mb_type_o = sub_mb_type_e'(info_r.sub_type[part_i]);   // part p at [3p+5:3p+3]

  // second vector of the pair sits in the next block
  assign base_nxt = base_i + 4'd1;
  assign imv0_o   = imv_r[base_i];
  assign imv1_o   = imv_r[base_nxt];

  assign qp_o           = qp_r;
  assign imv_o          = imv_r;            // echo for MC
  assign mb_type_info_o = info_r;

endmodule

// ==== verilog/fme_params.svh ====
// FME parameters
// widths and counts shared by the fractional motion estimation control
`ifndef FME_PARAMS_SVH
`define FME_PARAMS_SVH

// macroblock geometry
`define BLK4X4_NUM      16      // 4x4 blocks per macroblock
`define BLK8X8_NUM      4       // 8x8 parts per macroblock

// type info from IME
`define MB_TYPE_LEN     3
`define SUB_MB_TYPE_LEN 3

// motion vector components
`define IMVD_LEN        10      // integer pel
`define FMVD_LEN        12      // quarter pel

// costs and QP
`define COST_LEN        16      // one search
`define INTERCOST_LEN   18      // macroblock sum
`define QP_LEN          6

`endif

// ==== verilog/fme_part_ctrl.sv ====
// FME partition controller
// walks the partitions of the macroblock, runs a half pel then a quarter
// pel search for each step and flags quarter results for writeback
`timescale 1ns/100ps

module fme_part_ctrl import fme_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         start_fme_i,
  input  mb_type_e     mb_type_i,
  input  sub_mb_type_e sub_mb_type_i,
  input  mv_t          imv0_i,
  input  mv_t          imv1_i,
  input  qp_t          qp_i,
  input  logic         srch_done_i,
  output logic         load_o,
  output logic [1:0]   part_o,
  output blk_addr_t    base_o,
  output logic         srch_start_o,
  output srch_req_t    srch_req_o,
  output part_shape_e  shape_o,
  output logic         commit_o,
  output logic         done_fme_o
);

  fme_state_e  state_r;
  fme_state_e  state_nxt;
  logic [1:0]  part_r;      // 8x8 part, or 16x8 / 8x16 half
  logic        sub_r;       // second sub-partition of an 8x8
  logic        half_r;      // pass of the request in flight
  part_shape_e shape;
  blk_addr_t   base;
  logic        two_sub;
  logic        last_part;
  logic        last_step;
  logic        rsp_take;

  // --------------------
  // step decode
  always_comb begin
    shape     = SHAPE_16X16;
    base      = '0;
    two_sub   = 1'b0;
    last_part = 1'b1;
    case (mb_type_i)
      P_L0_L0_16X8: begin
        shape     = SHAPE_16X8;
        base      = {part_r[0], 3'b000};      // 0 or 8
        last_part = part_r[0];
      end
      P_L0_L0_8X16: begin
        shape     = SHAPE_8X16;
        base      = {1'b0, part_r[0], 2'b00}; // 0 or 4
        last_part = part_r[0];
      end
      P_8X8: begin
        base      = {part_r, sub_r, 1'b0};    // 4p + 2s
        last_part = &part_r;
        case (sub_mb_type_i)
          P_L0_8X4: begin
            shape   = SHAPE_8X4;
            two_sub = 1'b1;
          end
          P_L0_4X8: shape = SHAPE_4X8;
          P_L0_4X4: begin
            shape   = SHAPE_4X4;
            two_sub = 1'b1;
          end
          default:  shape = SHAPE_8X8;          // unknown sub types run as 8x8
        endcase
      end
      default: shape = SHAPE_16X16;
    endcase
  end

  assign last_step = last_part & (~two_sub | sub_r);
  assign rsp_take  = (state_r == FME_WAIT) & srch_done_i;

  // --------------------
  // FSM
  always_comb begin
    state_nxt = state_r;
    case (state_r)
      FME_IDLE: if (start_fme_i) state_nxt = FME_REQ;
      FME_REQ:  state_nxt = FME_WAIT;
      FME_WAIT: begin
        if (srch_done_i) begin
          state_nxt = (!half_r && last_step) ? FME_DONE : FME_REQ;
        end
      end
      default:  state_nxt = FME_IDLE;          // FME_DONE
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= FME_IDLE;
      part_r  <= '0;
      sub_r   <= 1'b0;
      half_r  <= 1'b0;
    end else begin
      state_r <= state_nxt;
      if (load_o) begin
        part_r <= '0;
        sub_r  <= 1'b0;
        half_r <= 1'b1;                        // every step opens with half pel
      end else if (rsp_take) begin
        if (half_r) begin
          half_r <= 1'b0;
        end else begin
          half_r <= ~last_step;
          if (last_step) begin
            part_r <= '0;
            sub_r  <= 1'b0;
          end else if (two_sub && !sub_r) begin
            sub_r <= 1'b1;
          end else begin
            sub_r  <= 1'b0;
            part_r <= part_r + 2'd1;
          end
        end
      end
    end
  end

  // --------------------
  // outputs
  assign load_o       = (state_r == FME_IDLE) & start_fme_i;
  assign srch_start_o = (state_r == FME_REQ);
  assign commit_o     = rsp_take & ~half_r;     // quarter results only
  assign done_fme_o   = (state_r == FME_DONE);
  assign part_o       = part_r;
  assign base_o       = base;
  assign shape_o      = shape;

  // stays put while waiting, counters move only on a response
  assign srch_req_o = '{half: half_r, shape: shape, imv0: imv0_i, imv1: imv1_i, qp: qp_i};

endmodule

// ==== verilog/fme_pkg.sv ====
// FME types
// vector typedefs, state and type enums, search request and response
`include "fme_params.svh"

package fme_pkg;

  // --------------------
  // vectors
  typedef logic [2*`IMVD_LEN-1:0]      mv_t;        // {y, x}
  typedef logic [2*`FMVD_LEN-1:0]      fmv_t;       // {y, x} quarter pel
  typedef mv_t  [`BLK4X4_NUM-1:0]      imv_vec_t;   // block 0 lowest
  typedef fmv_t [`BLK4X4_NUM-1:0]      fmv_vec_t;
  typedef logic [`COST_LEN-1:0]        cost_t;
  typedef logic [`INTERCOST_LEN-1:0]   intercost_t;
  typedef logic [3:0]                  blk_addr_t;  // 8x8 quadrant order
  typedef logic [`QP_LEN-1:0]          qp_t;

  // sub types of parts 3..0 above the macroblock type
  typedef struct packed {
    logic [`BLK8X8_NUM-1:0][`SUB_MB_TYPE_LEN-1:0] sub_type;
    logic [`MB_TYPE_LEN-1:0]                      mb_type;
  } mb_type_info_t;

  // --------------------
  // enums
  typedef enum logic [`MB_TYPE_LEN-1:0] {
    P_L0_16X16   = 3'd0,
    P_L0_L0_16X8 = 3'd1,
    P_L0_L0_8X16 = 3'd2,
    P_8X8        = 3'd3
  } mb_type_e;

  typedef enum logic [`SUB_MB_TYPE_LEN-1:0] {
    P_L0_8X8 = 3'd0,
    P_L0_8X4 = 3'd1,
    P_L0_4X8 = 3'd2,
    P_L0_4X4 = 3'd3
  } sub_mb_type_e;

  typedef enum logic [2:0] {
    SHAPE_16X16, SHAPE_16X8, SHAPE_8X16, SHAPE_8X8,
    SHAPE_8X4, SHAPE_4X8, SHAPE_4X4
  } part_shape_e;

  typedef enum logic [1:0] {FME_IDLE, FME_REQ, FME_WAIT, FME_DONE} fme_state_e;

  // --------------------
  // search engine interface
  typedef struct packed {
    logic        half;   // 1 half pel pass, 0 quarter pel pass
    part_shape_e shape;
    mv_t         imv0;
    mv_t         imv1;
    qp_t         qp;
  } srch_req_t;

  typedef struct packed {
    fmv_t  fmv0;
    fmv_t  fmv1;
    cost_t cost;
  } srch_rsp_t;

endpackage

// ==== verilog/fme_result.sv ====
// FME result writeback
// writes quarter pel vectors into the sixteen 4x4 slots by partition shape
// and sums the quarter pel costs into the inter cost
`timescale 1ns/100ps
`include "fme_params.svh"

module fme_result import fme_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        clear_i,
  input  logic        commit_i,
  input  part_shape_e shape_i,
  input  blk_addr_t   base_i,
  input  srch_rsp_t   srch_rsp_i,
  output fmv_vec_t    fmv_o,
  output intercost_t  intercost_o
);

  fmv_vec_t                fmv_r;
  intercost_t              cost_r;
  logic [`BLK4X4_NUM-1:0]  wr0_mask;   // slots taking fmv0
  logic [`BLK4X4_NUM-1:0]  wr1_mask;   // slots taking fmv1

  // --------------------
  // slot masks per shape
  // quadrant order makes each shape a fixed pattern shifted by base
  always_comb begin
    wr0_mask = '0;
    wr1_mask = '0;
    case (shape_i)
      SHAPE_16X16: wr0_mask = 16'hffff;
      SHAPE_16X8:  wr0_mask = 16'h00ff << base_i;   // two quadrants
      SHAPE_8X16:  wr0_mask = 16'h0f0f << base_i;   // quadrant and the one below
      SHAPE_8X8:   wr0_mask = 16'h000f << base_i;
      SHAPE_8X4:   wr0_mask = 16'h0003 << base_i;
      SHAPE_4X8: begin
        wr0_mask = 16'h0005 << base_i;             // left column
        wr1_mask = 16'h000a << base_i;             // right column
      end
      SHAPE_4X4: begin
        wr0_mask = 16'h0001 << base_i;
        wr1_mask = 16'h0002 << base_i;
      end
      default: begin
        wr0_mask = '0;
        wr1_mask = '0;
      end
    endcase
  end

  // --------------------
  // fmv slots
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fmv_r <= '0;
    end else if (clear_i) begin
      fmv_r <= '0;
    end else if (commit_i) begin
      for (int k = 0; k < `BLK4X4_NUM; k++) begin
        if (wr0_mask[k]) begin
          fmv_r[k] <= srch_rsp_i.fmv0;
        end else if (wr1_mask[k]) begin
          fmv_r[k] <= srch_rsp_i.fmv1;
        end
      end
    end
  end

  // --------------------
  // inter cost, wraps at 2^18
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cost_r <= '0;
    end else if (clear_i) begin
      cost_r <= '0;
    end else if (commit_i) begin
      cost_r <= cost_r + intercost_t'(srch_rsp_i.cost);
    end
  end

  assign fmv_o       = fmv_r;
  assign intercost_o = cost_r;

endmodule

// ==== verilog/fme_top.sv ====
// FME top level
// info latch, partition controller and result writeback around an
// external sub-pel search engine
`timescale 1ns/100ps

module fme_top import fme_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          start_fme_i,
  input  qp_t           qp_i,
  input  imv_vec_t      imv_i,
  input  mb_type_info_t mb_type_info_i,
  output logic          srch_start_o,
  output srch_req_t     srch_req_o,
  input  logic          srch_done_i,
  input  srch_rsp_t     srch_rsp_i,
  output logic          done_fme_o,
  output fmv_vec_t      fmv_o,
  output imv_vec_t      imv_o,
  output mb_type_info_t mb_type_info_o,
  output intercost_t    intercost_o
);

  logic         mb_load;      // start accepted, also clears the result
  logic [1:0]   part;
  blk_addr_t    base;
  mb_type_e     mb_type;
  sub_mb_type_e sub_mb_type;
  mv_t          imv0;
  mv_t          imv1;
  qp_t          qp_lat;
  part_shape_e  shape;
  logic         commit;

  fme_mb_info u_mb_info (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .load_i         (mb_load),
    .imv_i          (imv_i),
    .mb_type_info_i (mb_type_info_i),
    .qp_i           (qp_i),
    .part_i         (part),
    .base_i         (base),
    .mb_type_o      (mb_type),
    .sub_mb_type_o  (sub_mb_type),
    .imv0_o         (imv0),
    .imv1_o         (imv1),
    .qp_o           (qp_lat),
    .imv_o          (imv_o),
    .mb_type_info_o (mb_type_info_o)
  );

  fme_part_ctrl u_part_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_fme_i   (start_fme_i),
    .mb_type_i     (mb_type),
    .sub_mb_type_i (sub_mb_type),
    .imv0_i        (imv0),
    .imv1_i        (imv1),
    .qp_i          (qp_lat),
    .srch_done_i   (srch_done_i),
    .load_o        (mb_load),
    .part_o        (part),
    .base_o        (base),
    .srch_start_o  (srch_start_o),
    .srch_req_o    (srch_req_o),
    .shape_o       (shape),
    .commit_o      (commit),
    .done_fme_o    (done_fme_o)
  );

  fme_result u_result (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (mb_load),
    .commit_i    (commit),
    .shape_i     (shape),
    .base_i      (base),
    .srch_rsp_i  (srch_rsp_i),
    .fmv_o       (fmv_o),
    .intercost_o (intercost_o)
  );

endmodule
